// ==== testbench/decode_cases.txt ====
// op(8 chk,1 cfg,2 flush,f end) fvalid ferr addr insn bptaken rob_full rename_stall cfg
// exp: rob_v ren_v err ecause rsop imm target flags retop rs1 rs2 rd illegal_count
8_1_0_00001000_002081B3_0_0_0_0_1_1_0_2_00_00000000_00001000_60_00_01_02_03_0000
8_1_0_00001004_407302B3_0_0_0_0_1_1_0_2_08_00000000_00001004_60_00_06_07_05_0000
8_1_0_00001008_FFF10093_0_0_0_0_1_1_0_2_00_FFFFFFFF_00001004_50_00_02_1F_01_0000
8_1_0_0000100C_40325213_0_0_0_0_1_1_0_2_0D_00000403_0000140C_50_25_04_03_04_0000
8_1_0_00001010_00C4A403_0_0_0_0_1_1_0_2_02_0000000C_0000101C_58_02_09_0C_08_0000
8_1_0_00001014_FEA5AC23_0_0_0_0_1_1_0_2_0A_FFFFFFF8_0000100C_78_0A_0B_0A_38_0000
8_1_0_00001018_00208863_0_0_0_0_1_1_0_2_0C_00000010_00001028_60_40_01_02_30_0000
8_1_0_0000101C_00208863_1_0_0_0_1_1_0_2_0C_00000010_00001020_60_40_01_02_30_0000
8_1_0_00001020_100000EF_0_0_0_0_1_1_0_2_00_00000004_00001120_14_00_00_00_01_0000
8_1_0_00001024_00008067_0_0_0_0_1_1_0_2_00_00000000_00001028_51_10_01_00_20_0000
8_1_0_00001028_123453B7_0_0_0_0_1_1_0_2_00_12345000_12346028_10_25_08_03_07_0000
8_1_0_0000102C_00001117_0_0_0_0_1_1_0_2_00_00001000_0000202C_14_21_00_00_02_0000
8_1_0_00001030_300312F3_0_0_0_0_1_1_0_2_01_00000300_00001330_52_21_06_00_05_0000
8_1_0_00001034_300352F3_0_0_0_0_1_1_0_2_05_00000300_00001334_12_25_06_00_05_0000
8_1_0_00001038_0020B18B_0_0_0_0_1_1_0_2_03_00000000_00001038_68_23_01_02_03_0000
8_1_0_0000103C_022081AB_0_0_0_0_1_1_0_2_18_00000000_0000103C_60_00_01_02_03_0000
8_1_1_00001042_002081B3_0_0_0_0_1_0_1_0_00_00000000_00001040_60_00_01_02_03_0000
8_1_1_00001044_002081B3_0_0_0_0_1_0_1_1_00_00000000_00001044_60_00_01_02_03_0001
8_1_0_00001048_00002007_0_0_0_0_1_0_1_2_02_00000000_00001048_10_02_00_00_20_0002
1_0_0_00000000_00000000_0_0_0_0_0_0_0_0_00_00000000_00000000_00_00_00_00_00_0003
8_1_0_00001050_0020B18B_0_0_0_0_1_0_1_2_03_00000000_00001050_18_23_01_02_23_0003
8_1_0_00001054_022081AB_0_0_0_0_1_0_1_2_10_00000000_00001054_10_00_01_02_23_0004
1_0_0_00000000_00000000_0_0_0_3_0_0_0_0_00_00000000_00000000_00_00_00_00_00_0005
8_1_0_00001060_002081B3_0_0_0_0_1_1_0_2_00_00000000_00001060_60_00_01_02_03_0005
8_1_0_00001064_407302B3_0_1_0_0_1_0_0_2_00_00000000_00001060_60_00_01_02_03_0005
8_1_0_00001064_407302B3_0_0_1_0_0_1_0_2_00_00000000_00001060_60_00_01_02_03_0005
8_1_0_00001064_407302B3_0_0_0_0_1_1_0_2_08_00000000_00001064_60_00_06_07_05_0005
2_1_0_00001068_002081B3_0_0_0_0_0_0_0_0_00_00000000_00000000_00_00_00_00_00_0005
0_0_0_00000000_00000000_0_0_0_0_0_0_0_0_00_00000000_00000000_00_00_00_00_00_0005
F_0_0_00000000_00000000_0_0_0_0_0_0_0_0_00_00000000_00000000_00_00_00_00_00_0000

// ==== project.f ====
rtl/decode_pkg.sv
rtl/decode_format.sv
rtl/decode_stage.sv
rtl/decode_cfg_regs.sv
rtl/decode_unit.sv
testbench/decode_unit_checker.sv
testbench/decode_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/decode_unit_tb.sv ====
// decode unit testbench
`timescale 1ns/1ps
`default_nettype none

module decode_unit_tb;
  import decode_pkg::*;

  localparam int NCASES = 64;

  logic               clk;
  logic               reset_i;
  logic               fetch_valid_i;
  fetch_pkt_t         fetch_pkt_i;
  logic               decode_stall_o;
  logic               rob_valid_o;
  rob_req_t           rob_req_o;
  logic               rob_full_i;
  logic               rob_flush_i;
  logic [ROBID_W-1:0] rob_robid_i;
  logic               rename_valid_o;
  rename_req_t        rename_req_o;
  logic               rename_stall_i;
  logic               cfg_we_i;
  cfg_t               cfg_wdata_i;
  cfg_t               cfg_rdata_o;
  logic [ICNT_W-1:0]  illegal_count_o;

  logic [235:0]       cases [0:NCASES-1];
  logic [235:0]       held;
  logic [31:0]        lfsr;
  int                 idx;
  int                 n;

  decode_unit DUT (.*);

  always #5 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      abort("value check failed");
    end
  endtask

  task automatic drive(input logic [235:0] c);
    fetch_valid_i         = (c[231:228] != 4'h0);
    fetch_pkt_i.error     = c[224];
    fetch_pkt_i.addr      = c[223:193];
    fetch_pkt_i.insn      = c[191:160];
    // tag varies with the address
    fetch_pkt_i.bptag     = c[207:192] ^ 16'hbeef;
    fetch_pkt_i.bptaken   = c[156];
    rob_full_i            = c[152];
    rename_stall_i        = c[148];
    cfg_wdata_i           = c[145:144];
    cfg_we_i              = (c[235:232] == 4'h1);
    rob_flush_i           = (c[235:232] == 4'h2);
    for (int b = 0; b < ROBID_W; b++) begin
      lfsr           = lfsr_next(lfsr);
      rob_robid_i[b] = lfsr[0];
    end
  endtask

  // h is the last packet the stage accepted
  task automatic verify(input logic [235:0] c, input logic [235:0] h);
    check("decode_stall", decode_stall_o, c[152] | c[148]);
    check("rob_valid", rob_valid_o, c[140]);
    check("rename_valid", rename_valid_o, c[136]);
    check("illegal_count", illegal_count_o, c[15:0]);
    if (c[235:232] == 4'h1) begin
      check("cfg_rdata", cfg_rdata_o, c[145:144]);
    end
    // full request compare
    if (c[235]) begin
      check("error", rob_req_o.error, c[132]);
      check("ecause", rob_req_o.ecause, c[129:128]);
      check("rsop", rename_req_o.rsop, c[124:120]);
      check("imm", rename_req_o.imm, c[119:88]);
      check("rob target", {rob_req_o.target, 2'b00}, {c[87:58], 2'b00});
      check("rename target", {rename_req_o.target, 2'b00}, {c[87:58], 2'b00});
      check("use flags", {rename_req_o.uses_rs1, rename_req_o.uses_rs2,
                          rename_req_o.uses_imm, rename_req_o.uses_memory,
                          rename_req_o.uses_pc, rename_req_o.csr_access,
                          rename_req_o.inhibit}, c[54:48]);
      check("retop", rob_req_o.retop, c[46:40]);
      check("rs1", rename_req_o.rs1, c[36:32]);
      check("rs2", rename_req_o.rs2, c[28:24]);
      check("rob rd", rob_req_o.rd, c[21:16]);
      check("rename rd", rename_req_o.rd, c[21:16]);
      check("robid", rename_req_o.robid, rob_robid_i);
      check("rob addr", {rob_req_o.addr, 2'b00}, {h[223:194], 2'b00});
      check("rename addr", {rename_req_o.addr, 2'b00}, {h[223:194], 2'b00});
      check("bptaken", rob_req_o.bptaken, h[156]);
      check("bptag", rob_req_o.bptag, h[207:192] ^ 16'hbeef);
    end
  endtask

  initial begin
    clk            = 1'b0;
    reset_i        = 1'b1;
    // traffic during reset must be ignored
    fetch_valid_i  = 1'b1;
    fetch_pkt_i    = '0;
    rob_full_i     = 1'b0;
    rob_flush_i    = 1'b0;
    rob_robid_i    = '0;
    rename_stall_i = 1'b0;
    cfg_we_i       = 1'b1;
    cfg_wdata_i    = '0;
    held           = '0;
    lfsr           = 32'hefb0;
    $readmemh("testbench/decode_cases.txt", cases);
    for (n = 0; n < 10; n++) begin
      @(posedge clk);
    end
    @(negedge clk);
    reset_i       = 1'b0;
    fetch_valid_i = 1'b0;
    cfg_we_i      = 1'b0;
    check("reset rob_valid", rob_valid_o, 1'b0);
    check("reset rename_valid", rename_valid_o, 1'b0);
    check("reset cfg", cfg_rdata_o, 2'b11);
    check("reset count", illegal_count_o, 16'd0);
    idx = 0;
    while (cases[idx][235:232] !== 4'hf) begin
      if (idx == NCASES - 1 || $isunknown(cases[idx])) begin
        abort("case file has no end marker");
      end
      drive(cases[idx]);
      // a packet is taken only when the stage is not stalled
      if (cases[idx][231:228] != 4'h0 && !cases[idx][152] && !cases[idx][148]) begin
        held = cases[idx];
      end
      @(posedge clk);
      @(negedge clk);
      verify(cases[idx], held);
      idx++;
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/decode_unit_checker.sv ====
// decode stage assertions
`timescale 1ns/1ps
`default_nettype none

module decode_unit_checker (
  input wire                       clk,
  input wire                       reset_i,
  input wire                       rob_flush_i,
  input wire                       decode_stall_o,
  input wire                       rob_valid_o,
  input wire [31:0]                insn_o,
  input wire decode_pkg::rob_req_t rob_req_o,
  input wire                       rename_valid_o
);

  // latched packet holds across a stalled edge
  assert property (@(posedge clk) disable iff (reset_i)
    decode_stall_o |=> ($stable(insn_o) && $stable(rob_req_o)))
    else $error("outputs changed while the stage was stalled");

  assert property (@(posedge clk) disable iff (reset_i)
    rob_flush_i |=> (!rob_valid_o && !rename_valid_o))
    else $error("valid output still set one cycle after a flush");

  assert property (@(posedge clk) disable iff (reset_i)
    !(rename_valid_o && rob_req_o.error))
    else $error("rename valid raised with an error packet");

endmodule

bind decode_stage decode_unit_checker u_checker (
  .clk            (clk),
  .reset_i        (reset_i),
  .rob_flush_i    (rob_flush_i),
  .decode_stall_o (decode_stall_o),
  .rob_valid_o    (rob_valid_o),
  .insn_o         (insn_o),
  .rob_req_o      (rob_req_o),
  .rename_valid_o (rename_valid_o)
);

`default_nettype wire

// ==== rtl/decode_unit.sv ====
// decode subsystem top
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  wire                              clk,
  input  wire                              reset_i,
  input  wire                              fetch_valid_i,
  input  wire decode_pkg::fetch_pkt_t      fetch_pkt_i,
  output logic                             decode_stall_o,
  output logic                             rob_valid_o,
  output decode_pkg::rob_req_t             rob_req_o,
  input  wire                              rob_full_i,
  input  wire                              rob_flush_i,
  input  wire [decode_pkg::ROBID_W-1:0]    rob_robid_i,
  output logic                             rename_valid_o,
  output decode_pkg::rename_req_t          rename_req_o,
  input  wire                              rename_stall_i,
  input  wire                              cfg_we_i,
  input  wire decode_pkg::cfg_t            cfg_wdata_i,
  output decode_pkg::cfg_t                 cfg_rdata_o,
  output logic [decode_pkg::ICNT_W-1:0]    illegal_count_o
);
  import decode_pkg::*;

  logic [31:0] insn;
  fmt_t        fmt;
  logic        illegal_pulse;

  decode_stage u_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_pkt_i     (fetch_pkt_i),
    .fmt_i           (fmt),
    .rob_full_i      (rob_full_i),
    .rob_flush_i     (rob_flush_i),
    .rob_robid_i     (rob_robid_i),
    .rename_stall_i  (rename_stall_i),
    .insn_o          (insn),
    .decode_stall_o  (decode_stall_o),
    .rob_valid_o     (rob_valid_o),
    .rob_req_o       (rob_req_o),
    .rename_valid_o  (rename_valid_o),
    .rename_req_o    (rename_req_o),
    .illegal_pulse_o (illegal_pulse)
  );

  decode_format u_format (
    .insn_i (insn),
    .cfg_i  (cfg_rdata_o),
    .fmt_o  (fmt)
  );

  decode_cfg_regs u_cfg (
    .clk             (clk),
    .reset_i         (reset_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .illegal_pulse_i (illegal_pulse),
    .cfg_o           (cfg_rdata_o),
    .illegal_count_o (illegal_count_o)
  );

endmodule

`default_nettype wire

// ==== rtl/decode_cfg_regs.sv ====
// decode configuration registers
`timescale 1ns/1ps
`default_nettype none

module decode_cfg_regs (
  input  wire                           clk,
  input  wire                           reset_i,
  input  wire                           cfg_we_i,
  input  wire decode_pkg::cfg_t         cfg_wdata_i,
  input  wire                           illegal_pulse_i,
  output decode_pkg::cfg_t              cfg_o,
  output logic [decode_pkg::ICNT_W-1:0] illegal_count_o
);
  import decode_pkg::*;

  cfg_t              cfg_q;
  logic [ICNT_W-1:0] count_q;

  // custom groups enabled out of reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfg_q <= '{custom0_en: 1'b1, custom1_en: 1'b1};
    end else if (cfg_we_i) begin
      cfg_q <= cfg_wdata_i;
    end
  end

  // saturates at all ones
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (illegal_pulse_i && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign cfg_o           = cfg_q;
  assign illegal_count_o = count_q;

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// decode stage register and request builder
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                              clk,
  input  wire                              reset_i,
  input  wire                              fetch_valid_i,
  input  wire decode_pkg::fetch_pkt_t      fetch_pkt_i,
  input  wire decode_pkg::fmt_t            fmt_i,
  input  wire                              rob_full_i,
  input  wire                              rob_flush_i,
  input  wire [decode_pkg::ROBID_W-1:0]    rob_robid_i,
  input  wire                              rename_stall_i,
  output logic [31:0]                      insn_o,
  output logic                             decode_stall_o,
  output logic                             rob_valid_o,
  output decode_pkg::rob_req_t             rob_req_o,
  output logic                             rename_valid_o,
  output decode_pkg::rename_req_t          rename_req_o,
  output logic                             illegal_pulse_o
);
  import decode_pkg::*;

  logic        valid_q;
  fetch_pkt_t  pkt_q;

  logic [4:0]  opc;
  logic [2:0]  funct3;
  logic [2:0]  brop;
  logic        insn_load;
  logic        insn_jalr;
  logic        insn_auipc;
  logic        insn_csr;
  logic        insn_lbcmp;
  logic        insn_aluext;
  logic        insn_complex;
  logic        altop;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        uses_rd;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        uses_memory;
  logic        error;
  ecause_e     ecause;
  logic        target_ntaken;
  logic [31:1] target;
  logic [4:0]  rsop;

  assign decode_stall_o = rob_full_i | rename_stall_i;

  always_ff @(posedge clk) begin
    if (reset_i || rob_flush_i) begin
      valid_q <= 1'b0;
    end else if (!decode_stall_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!decode_stall_o && fetch_valid_i) begin
      pkt_q <= fetch_pkt_i;
    end
  end

  assign insn_o = pkt_q.insn;
  assign opc    = pkt_q.insn[6:2];
  assign funct3 = pkt_q.insn[14:12];
  assign rs1    = pkt_q.insn[19:15];
  assign rs2    = pkt_q.insn[24:20];
  assign rd     = pkt_q.insn[11:7];

  // instruction classes
  assign insn_load    = (opc == OPC_LOAD);
  assign insn_jalr    = (opc == OPC_JALR);
  assign insn_auipc   = (opc == OPC_AUIPC);
  assign insn_csr     = (opc == OPC_SYSTEM) && (funct3[1:0] != 2'b00);
  assign insn_lbcmp   = (opc == OPC_CUSTOM0) && (funct3[1:0] == 2'b11);
  assign insn_aluext  = (opc == OPC_CUSTOM1);
  assign insn_complex = fmt_i.r & pkt_q.insn[25];

  // srai/srli share funct3 101, insn[30] picks the arithmetic form
  assign altop = (fmt_i.r | (funct3 == 3'b101)) & pkt_q.insn[30];
  assign brop  = {~|funct3[2:1], funct3[2:1]};

  assign uses_rd     = (fmt_i.r | fmt_i.i | fmt_i.u | fmt_i.j) & (rd != 5'd0);
  // csr immediate forms take no rs1
  assign uses_rs1    = fmt_i.r | (fmt_i.i & (~insn_csr | ~funct3[2])) | fmt_i.s | fmt_i.b;
  assign uses_rs2    = fmt_i.r | fmt_i.s | fmt_i.b;
  assign uses_memory = insn_load | fmt_i.s | insn_lbcmp;

  assign error  = pkt_q.error | fmt_i.inv;
  assign ecause = pkt_q.error ? (pkt_q.addr[1] ? ERR_IALIGN : ERR_IFAULT) : ERR_IILLEGAL;

  // fall-through target when predicted taken or indirect
  assign target_ntaken = (fmt_i.b & pkt_q.bptaken) | insn_jalr;
  assign target = {pkt_q.addr[31:2], 1'b0} + (target_ntaken ? 31'd2 : fmt_i.imm[31:1]);

  always_comb begin
    if (uses_memory) begin
      rsop = {1'b0, fmt_i.s, funct3};
    end else if (fmt_i.j || insn_jalr || fmt_i.u) begin
      rsop = 5'b00000;
    end else if (fmt_i.b) begin
      rsop = {2'b01, brop};
    end else begin
      rsop = {insn_complex | insn_aluext, insn_complex | altop, funct3};
    end
  end

  assign rob_valid_o     = valid_q & ~rename_stall_i;
  assign rename_valid_o  = valid_q & ~error & ~rob_full_i;
  assign illegal_pulse_o = valid_q & ~decode_stall_o & error;

  always_comb begin
    rob_req_o.error   = error;
    rob_req_o.ecause  = ecause;
    rob_req_o.retop   = {fmt_i.b, funct3[0], insn_jalr, fmt_i.s, funct3};
    rob_req_o.bptag   = pkt_q.bptag;
    rob_req_o.bptaken = pkt_q.bptaken;
    rob_req_o.rd      = {~uses_rd, rd};
    rob_req_o.addr    = pkt_q.addr[31:2];
    rob_req_o.forward = insn_jalr;
    rob_req_o.target  = target[31:2];
  end

  always_comb begin
    rename_req_o.rsop        = rsop;
    rename_req_o.robid       = rob_robid_i;
    rename_req_o.uses_rs1    = uses_rs1;
    rename_req_o.uses_rs2    = uses_rs2;
    rename_req_o.uses_imm    = ~fmt_i.r & ~fmt_i.b;
    rename_req_o.uses_memory = uses_memory;
    rename_req_o.uses_pc     = fmt_i.j | insn_auipc;
    rename_req_o.csr_access  = insn_csr;
    rename_req_o.inhibit     = insn_jalr;
    rename_req_o.rs1         = rs1;
    rename_req_o.rs2         = rs2;
    rename_req_o.rd          = {~uses_rd, rd};
    rename_req_o.addr        = pkt_q.addr[31:2];
    rename_req_o.target      = target[31:2];
    // jal writes the link address, pc + 4
    rename_req_o.imm         = fmt_i.j ? 32'd4 : fmt_i.imm;
  end

endmodule

`default_nettype wire

// ==== rtl/decode_format.sv ====
// instruction format classifier
`timescale 1ns/1ps
`default_nettype none

module decode_format (
  input  wire [31:0]            insn_i,
  input  wire decode_pkg::cfg_t cfg_i,
  output decode_pkg::fmt_t      fmt_o
);
  import decode_pkg::*;

  logic [4:0]  opc;
  logic        is_r;
  logic        is_i;
  logic        is_s;
  logic        is_b;
  logic        is_u;
  logic        is_j;
  logic        is_inv;
  logic [31:0] imm;

  assign opc = insn_i[6:2];

  always_comb begin
    is_r   = 1'b0;
    is_i   = 1'b0;
    is_s   = 1'b0;
    is_b   = 1'b0;
    is_u   = 1'b0;
    is_j   = 1'b0;
    is_inv = 1'b0;
    // compressed encodings are not supported
    if (insn_i[1:0] != 2'b11) begin
      is_inv = 1'b1;
    end else begin
      case (opc)
        OPC_OP:                          is_r = 1'b1;
        OPC_OPIMM, OPC_LOAD, OPC_JALR:   is_i = 1'b1;
        OPC_MISCMEM, OPC_SYSTEM:         is_i = 1'b1;
        OPC_LUI, OPC_AUIPC:              is_u = 1'b1;
        OPC_STORE:                       is_s = 1'b1;
        OPC_BRANCH:                      is_b = 1'b1;
        OPC_JAL:                         is_j = 1'b1;
        OPC_CUSTOM0: begin
          is_r   = cfg_i.custom0_en;
          is_inv = ~cfg_i.custom0_en;
        end
        OPC_CUSTOM1: begin
          is_r   = cfg_i.custom1_en;
          is_inv = ~cfg_i.custom1_en;
        end
        // fp, amo, rv64, custom2/3, reserved and long encodings
        default:                         is_inv = 1'b1;
      endcase
    end
  end

  // sign-extended immediate per format
  always_comb begin
    case (1'b1)
      is_i:    imm = {{20{insn_i[31]}}, insn_i[31:20]};
      is_s:    imm = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
      is_b:    imm = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                      insn_i[11:8], 1'b0};
      is_u:    imm = {insn_i[31:12], 12'b0};
      is_j:    imm = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                      insn_i[30:21], 1'b0};
      default: imm = 32'd0;
    endcase
  end

  assign fmt_o = '{
    r:   is_r,
    i:   is_i,
    s:   is_s,
    b:   is_b,
    u:   is_u,
    j:   is_j,
    inv: is_inv,
    imm: imm
  };

endmodule

`default_nettype wire

// ==== rtl/decode_pkg.sv ====
// decode stage definitions
`default_nettype none

package decode_pkg;

  localparam int ROBID_W = 7;
  localparam int BPTAG_W = 16;
  localparam int ICNT_W  = 16;

  // major opcodes, insn[6:2]
  localparam logic [4:0] OPC_LOAD      = 5'b00000;
  localparam logic [4:0] OPC_LOADFP    = 5'b00001;
  localparam logic [4:0] OPC_CUSTOM0   = 5'b00010;
  localparam logic [4:0] OPC_MISCMEM   = 5'b00011;
  localparam logic [4:0] OPC_OPIMM     = 5'b00100;
  localparam logic [4:0] OPC_AUIPC     = 5'b00101;
  localparam logic [4:0] OPC_OPIMM32   = 5'b00110;
  localparam logic [4:0] OPC_48B0      = 5'b00111;
  localparam logic [4:0] OPC_STORE     = 5'b01000;
  localparam logic [4:0] OPC_STOREFP   = 5'b01001;
  localparam logic [4:0] OPC_CUSTOM1   = 5'b01010;
  localparam logic [4:0] OPC_AMO       = 5'b01011;
  localparam logic [4:0] OPC_OP        = 5'b01100;
  localparam logic [4:0] OPC_LUI       = 5'b01101;
  localparam logic [4:0] OPC_OP32      = 5'b01110;
  localparam logic [4:0] OPC_64B       = 5'b01111;
  localparam logic [4:0] OPC_MADD      = 5'b10000;
  localparam logic [4:0] OPC_MSUB      = 5'b10001;
  localparam logic [4:0] OPC_NMSUB     = 5'b10010;
  localparam logic [4:0] OPC_NMADD     = 5'b10011;
  localparam logic [4:0] OPC_OPFP      = 5'b10100;
  localparam logic [4:0] OPC_RESERVED0 = 5'b10101;
  localparam logic [4:0] OPC_CUSTOM2   = 5'b10110;
  localparam logic [4:0] OPC_48B1      = 5'b10111;
  localparam logic [4:0] OPC_BRANCH    = 5'b11000;
  localparam logic [4:0] OPC_JALR      = 5'b11001;
  localparam logic [4:0] OPC_RESERVED1 = 5'b11010;
  localparam logic [4:0] OPC_JAL       = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM    = 5'b11100;
  localparam logic [4:0] OPC_RESERVED2 = 5'b11101;
  localparam logic [4:0] OPC_CUSTOM3   = 5'b11110;
  localparam logic [4:0] OPC_80B       = 5'b11111;

  typedef enum logic [1:0] {
    ERR_IALIGN   = 2'd0,
    ERR_IFAULT   = 2'd1,
    ERR_IILLEGAL = 2'd2
  } ecause_e;

  typedef struct packed {
    logic               error;
    logic [31:1]        addr;
    logic [31:0]        insn;
    logic [BPTAG_W-1:0] bptag;
    logic               bptaken;
  } fetch_pkt_t;

  // one-hot format flags
  typedef struct packed {
    logic        r;
    logic        i;
    logic        s;
    logic        b;
    logic        u;
    logic        j;
    logic        inv;
    logic [31:0] imm;
  } fmt_t;

  // rd[5] set means no destination
  typedef struct packed {
    logic               error;
    ecause_e            ecause;
    logic [6:0]         retop;
    logic [BPTAG_W-1:0] bptag;
    logic               bptaken;
    logic [5:0]         rd;
    logic [31:2]        addr;
    logic               forward;
    logic [31:2]        target;
  } rob_req_t;

  typedef struct packed {
    logic [4:0]         rsop;
    logic [ROBID_W-1:0] robid;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               uses_imm;
    logic               uses_memory;
    logic               uses_pc;
    logic               csr_access;
    logic               inhibit;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [5:0]         rd;
    logic [31:2]        addr;
    logic [31:2]        target;
    logic [31:0]        imm;
  } rename_req_t;

  typedef struct packed {
    logic custom0_en;
    logic custom1_en;
  } cfg_t;

endpackage

`default_nettype wire
